//--- source/smpc_pkg.sv
package smpc_pkg;

	localparam int OREG_AW = 5;
	localparam int DATA_W  = 8;

	localparam logic [OREG_AW-1:0] OREG_RESULT_IDX = 5'd31;	// Command code echo
	localparam logic [OREG_AW-1:0] OREG_STATUS_IDX = 5'd10;	// System status byte

	typedef enum logic [DATA_W-1:0] {
		MSHON   = 8'h00,
		SSHON   = 8'h02,
		SSHOFF  = 8'h03,
		SNDON   = 8'h06,
		SNDOFF  = 8'h07,
		CDON    = 8'h08,
		CDOFF   = 8'h09,
		SYSRES  = 8'h0D,
		NMIREQ  = 8'h18,
		RESENAB = 8'h19,
		RESDISA = 8'h1A
	} cmd_e;

	// Host bus to FSM, ready returns on its own wire
	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] code;
	} cmd_req_t;

	// All active low
	typedef struct packed {
		logic mshres_n;
		logic mshnmi_n;
		logic sshres_n;
		logic sshnmi_n;
		logic sysres_n;
		logic sndres_n;
		logic cdres_n;
	} reset_lines_t;

	typedef struct packed {
		logic               we;
		logic [OREG_AW-1:0] addr;
		logic [DATA_W-1:0]  data;
	} oreg_wr_t;

	typedef enum logic [4:0] {
		IDLE  = 5'b00001,
		START = 5'b00010,
		WAIT  = 5'b00100,
		EXEC  = 5'b01000,
		END   = 5'b10000
	} cmd_state_e;

endpackage

//--- source/smpc_host_bus.sv
`timescale 1ns/1ps

module smpc_host_bus (
	input  logic                          CLK,
	input  logic                          RST_N,
	input  logic                          CE,
	input  logic [6:1]                    a,
	input  logic [smpc_pkg::DATA_W-1:0]   di,
	input  logic                          cs_n,
	input  logic                          rw_n,
	input  logic                          cmd_ready,
	input  logic                          sf_clear,
	input  logic [smpc_pkg::DATA_W-1:0]   oreg_q,
	output smpc_pkg::cmd_req_t            cmd_req,
	output logic [smpc_pkg::OREG_AW-1:0]  oreg_raddr,
	output logic [smpc_pkg::DATA_W-1:0]   dout
);

	localparam logic [6:0] ADDR_COMREG  = 7'h1F;
	localparam logic [6:0] ADDR_SF      = 7'h63;
	localparam logic [6:0] ADDR_OREG_LO = 7'h21;
	localparam logic [6:0] ADDR_OREG_HI = 7'h5F;

	logic [6:0] addr;
	logic [5:0] oreg_off;
	logic       cs_n_old;
	logic       rw_n_old;
	logic       wr_edge;
	logic       rd_edge;
	logic       sf;

	assign addr       = {a, 1'b1};	// Odd byte lane only
	assign oreg_off   = a - 6'h10;
	assign oreg_raddr = oreg_off[smpc_pkg::OREG_AW-1:0];

	assign wr_edge = !rw_n && rw_n_old && !cs_n;
	assign rd_edge = !cs_n && cs_n_old && rw_n;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cs_n_old <= 1'b1;
			rw_n_old <= 1'b1;
			cmd_req  <= '0;
			sf       <= 1'b0;
			dout     <= '0;
		end else if (CE) begin
			cs_n_old <= cs_n;
			rw_n_old <= rw_n;

			if (cmd_req.valid && cmd_ready)
				cmd_req.valid <= 1'b0;	// Handed to FSM

			if (sf_clear)
				sf <= 1'b0;

			// A write in the handshake cycle still leaves a new pending code
			if (wr_edge) begin
				case (addr)
					ADDR_COMREG: begin
						cmd_req.code  <= di;	// Last write wins
						cmd_req.valid <= 1'b1;
					end
					ADDR_SF: begin
						if (di[0])
							sf <= 1'b1;
					end
					default: ;
				endcase
			end

			if (rd_edge) begin
				if (addr >= ADDR_OREG_LO && addr <= ADDR_OREG_HI)
					dout <= oreg_q;
				else if (addr == ADDR_SF)
					dout <= {{(smpc_pkg::DATA_W-1){1'b0}}, sf};
				else
					dout <= '0;
			end
		end
	end

endmodule

//--- source/smpc_cmd_fsm.sv
`timescale 1ns/1ps

module smpc_cmd_fsm (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         CE,
	input  smpc_pkg::cmd_req_t           cmd_req,
	input  logic                         timer_done,
	input  logic [smpc_pkg::DATA_W-1:0]  status_byte,
	output logic                         cmd_ready,
	output logic                         timer_start,
	output logic [smpc_pkg::DATA_W-1:0]  cmd_code,
	output logic                         cmd_apply,
	output logic                         cmd_release,
	output logic                         sf_clear,
	output smpc_pkg::oreg_wr_t           oreg_wr
);

	smpc_pkg::cmd_state_e state;
	smpc_pkg::cmd_state_e state_next;

	always_comb begin
		state_next = state;
		case (state)
			smpc_pkg::IDLE: begin
				if (cmd_req.valid)
					state_next = smpc_pkg::START;
			end
			smpc_pkg::START: state_next = smpc_pkg::WAIT;
			smpc_pkg::WAIT: begin
				if (timer_done)
					state_next = smpc_pkg::EXEC;
			end
			smpc_pkg::EXEC: state_next = smpc_pkg::END;
			smpc_pkg::END:  state_next = smpc_pkg::IDLE;
			default:        state_next = smpc_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			state <= smpc_pkg::IDLE;
		else if (CE)
			state <= state_next;
	end

	// Code held for the whole sequence
	always_ff @(posedge CLK) begin
		if (CE && cmd_req.valid && cmd_ready)
			cmd_code <= cmd_req.code;
	end

	assign cmd_ready   = (state == smpc_pkg::IDLE);
	assign timer_start = (state == smpc_pkg::START);
	assign cmd_apply   = (state == smpc_pkg::EXEC);
	assign sf_clear    = (state == smpc_pkg::EXEC);
	assign cmd_release = (state == smpc_pkg::END);

	always_comb begin
		oreg_wr = '0;
		if (state == smpc_pkg::EXEC) begin
			oreg_wr.we   = 1'b1;
			oreg_wr.addr = smpc_pkg::OREG_RESULT_IDX;
			oreg_wr.data = cmd_code;
		end else if (state == smpc_pkg::END) begin
			oreg_wr.we   = 1'b1;
			oreg_wr.addr = smpc_pkg::OREG_STATUS_IDX;
			oreg_wr.data = status_byte;	// Lines after apply, before release
		end
	end

endmodule

//--- source/smpc_wait_timer.sv
`timescale 1ns/1ps

module smpc_wait_timer #(
	parameter int WAIT_DIV = 1
) (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         CE,
	input  logic                         timer_start,
	input  logic [smpc_pkg::DATA_W-1:0]  cmd_code,
	output logic                         timer_done
);

	localparam int MAX_WAIT = 400;
	localparam int CNT_W    = $clog2(MAX_WAIT * WAIT_DIV + 1);

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] load_val;

	function automatic logic [8:0] wait_len(input logic [smpc_pkg::DATA_W-1:0] code);
		case (code)
			smpc_pkg::MSHON, smpc_pkg::SSHON, smpc_pkg::SSHOFF,
			smpc_pkg::SNDON, smpc_pkg::SNDOFF:                     wait_len = 9'd120;
			smpc_pkg::CDON, smpc_pkg::CDOFF:                       wait_len = 9'd159;
			smpc_pkg::SYSRES:                                      wait_len = 9'(MAX_WAIT);
			smpc_pkg::NMIREQ, smpc_pkg::RESENAB, smpc_pkg::RESDISA: wait_len = 9'd127;
			default:                                               wait_len = 9'd0;
		endcase
	endfunction

	assign load_val = CNT_W'(wait_len(cmd_code)) * CNT_W'(WAIT_DIV);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			count <= '0;
		else if (CE) begin
			if (timer_start)
				count <= load_val;
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	assign timer_done = (count == '0);

endmodule

//--- source/smpc_reset_ctrl.sv
`timescale 1ns/1ps

module smpc_reset_ctrl (
	input  logic                         CLK,
	input  logic                         RST_N,
	input  logic                         CE,
	input  logic                         MRES_N,
	input  logic [smpc_pkg::DATA_W-1:0]  cmd_code,
	input  logic                         cmd_apply,
	input  logic                         cmd_release,
	output smpc_pkg::reset_lines_t       lines,
	output logic [smpc_pkg::DATA_W-1:0]  status_byte
);

	// Slave CPU and sound stay in reset after power on
	localparam smpc_pkg::reset_lines_t POWER_ON = '{
		mshres_n: 1'b1,
		mshnmi_n: 1'b1,
		sshres_n: 1'b0,
		sshnmi_n: 1'b1,
		sysres_n: 1'b1,
		sndres_n: 1'b0,
		cdres_n:  1'b1
	};

	logic resd;	// Reset button disable

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			lines <= '0;
			resd  <= 1'b1;
		end else if (!MRES_N) begin
			lines <= POWER_ON;
			resd  <= 1'b1;
		end else if (CE) begin
			if (cmd_apply) begin
				case (cmd_code)
					smpc_pkg::MSHON: begin
						lines.mshres_n <= 1'b1;
						lines.mshnmi_n <= 1'b1;
					end
					smpc_pkg::SSHON: begin
						lines.sshres_n <= 1'b1;
						lines.sshnmi_n <= 1'b1;
					end
					smpc_pkg::SSHOFF: begin
						lines.sshres_n <= 1'b0;
						lines.sshnmi_n <= 1'b1;
					end
					smpc_pkg::SNDON:   lines.sndres_n <= 1'b1;
					smpc_pkg::SNDOFF:  lines.sndres_n <= 1'b0;
					smpc_pkg::CDON:    lines.cdres_n  <= 1'b1;
					smpc_pkg::CDOFF:   lines.cdres_n  <= 1'b0;
					smpc_pkg::SYSRES:  lines <= '0;	// Whole system into reset
					smpc_pkg::NMIREQ:  lines.mshnmi_n <= 1'b0;
					smpc_pkg::RESENAB: resd <= 1'b0;
					smpc_pkg::RESDISA: resd <= 1'b1;
					default: ;
				endcase
			end else if (cmd_release) begin
				case (cmd_code)
					smpc_pkg::SYSRES: lines <= '1;
					smpc_pkg::NMIREQ: lines.mshnmi_n <= 1'b1;	// End of NMI pulse
					default: ;
				endcase
			end
		end
	end

	assign status_byte = {
		resd,
		~lines.cdres_n,
		2'b11,
		~lines.mshnmi_n,
		1'b1,
		~lines.sysres_n,
		~lines.sndres_n
	};

endmodule

//--- source/smpc_oreg_ram.sv
`timescale 1ns/1ps

module smpc_oreg_ram (
	input  logic                         CLK,
	input  smpc_pkg::oreg_wr_t           oreg_wr,
	input  logic [smpc_pkg::OREG_AW-1:0] raddr,
	output logic [smpc_pkg::DATA_W-1:0]  q
);

	localparam int DEPTH = 1 << smpc_pkg::OREG_AW;

	logic [smpc_pkg::DATA_W-1:0] mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (oreg_wr.we)
			mem[oreg_wr.addr] <= oreg_wr.data;
	end

	assign q = mem[raddr];	// Async read for the host

endmodule

//--- source/smpc_top.sv
`timescale 1ns/1ps

module smpc_top #(
	parameter int WAIT_DIV = 1
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  logic       MRES_N,
	input  logic [6:1] a,
	input  logic [7:0] di,
	input  logic       cs_n,
	input  logic       rw_n,
	output logic [7:0] dout,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sysres_n,
	output logic       sndres_n,
	output logic       cdres_n
);

	smpc_pkg::cmd_req_t            cmd_req;
	smpc_pkg::oreg_wr_t            oreg_wr;
	smpc_pkg::reset_lines_t        lines;
	logic                          cmd_ready;
	logic                          sf_clear;
	logic                          timer_start;
	logic                          timer_done;
	logic                          cmd_apply;
	logic                          cmd_release;
	logic [smpc_pkg::DATA_W-1:0]   cmd_code;
	logic [smpc_pkg::DATA_W-1:0]   status_byte;
	logic [smpc_pkg::DATA_W-1:0]   oreg_q;
	logic [smpc_pkg::OREG_AW-1:0]  oreg_raddr;

	smpc_host_bus u_host_bus (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.CE         (CE),
		.a          (a),
		.di         (di),
		.cs_n       (cs_n),
		.rw_n       (rw_n),
		.cmd_ready  (cmd_ready),
		.sf_clear   (sf_clear),
		.oreg_q     (oreg_q),
		.cmd_req    (cmd_req),
		.oreg_raddr (oreg_raddr),
		.dout       (dout)
	);

	smpc_cmd_fsm u_cmd_fsm (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.CE          (CE),
		.cmd_req     (cmd_req),
		.timer_done  (timer_done),
		.status_byte (status_byte),
		.cmd_ready   (cmd_ready),
		.timer_start (timer_start),
		.cmd_code    (cmd_code),
		.cmd_apply   (cmd_apply),
		.cmd_release (cmd_release),
		.sf_clear    (sf_clear),
		.oreg_wr     (oreg_wr)
	);

	smpc_wait_timer #(
		.WAIT_DIV (WAIT_DIV)
	) u_wait_timer (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.CE          (CE),
		.timer_start (timer_start),
		.cmd_code    (cmd_code),
		.timer_done  (timer_done)
	);

	smpc_reset_ctrl u_reset_ctrl (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.CE          (CE),
		.MRES_N      (MRES_N),
		.cmd_code    (cmd_code),
		.cmd_apply   (cmd_apply),
		.cmd_release (cmd_release),
		.lines       (lines),
		.status_byte (status_byte)
	);

	smpc_oreg_ram u_oreg_ram (
		.CLK     (CLK),
		.oreg_wr (oreg_wr),
		.raddr   (oreg_raddr),
		.q       (oreg_q)
	);

	assign mshres_n = lines.mshres_n;
	assign mshnmi_n = lines.mshnmi_n;
	assign sshres_n = lines.sshres_n;
	assign sshnmi_n = lines.sshnmi_n;
	assign sysres_n = lines.sysres_n;
	assign sndres_n = lines.sndres_n;
	assign cdres_n  = lines.cdres_n;

endmodule

//--- tb/smpc_tb.sv
`timescale 1ns/1ps

module smpc_tb;

	localparam logic [6:0] ADDR_COMREG = 7'h1F;
	localparam logic [6:0] ADDR_SF     = 7'h63;
	localparam logic [6:0] ADDR_OREG31 = 7'h5F;	// 0x20 + 2*31 + 1
	localparam logic [6:0] ADDR_OREG10 = 7'h35;
	localparam int         TIMEOUT     = 20000;	// About 15 commands of up to 400 cycles

	logic       CLK;
	logic       RST_N;
	logic       CE;
	logic       MRES_N;
	logic [6:1] a;
	logic [7:0] di;
	logic       cs_n;
	logic       rw_n;
	logic [7:0] dout;
	logic [6:0] pins;	// Same bit order as reset_lines_t
	int         cycles;
	logic [7:0] rdata;
	logic       model_resd;
	smpc_pkg::reset_lines_t model;

	smpc_top #(
		.WAIT_DIV (1)
	) DUT (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.MRES_N   (MRES_N),
		.a        (a),
		.di       (di),
		.cs_n     (cs_n),
		.rw_n     (rw_n),
		.dout     (dout),
		.mshres_n (pins[6]),
		.mshnmi_n (pins[5]),
		.sshres_n (pins[4]),
		.sshnmi_n (pins[3]),
		.sysres_n (pins[2]),
		.sndres_n (pins[1]),
		.cdres_n  (pins[0])
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Run timed out after %0d cycles before all tests finished", cycles);
			$display("Done: errors found");
			$fatal(1, "Timeout");
		end
	end

	task automatic check(input logic [7:0] got, input logic [7:0] exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s (got %02h, expected %02h)", $time, msg, got, exp);
			$display("Done: errors found");
			$fatal(1, "Check failed");
		end
	endtask

	task automatic check_lines(input string msg);
		@(negedge CLK);
		check({1'b0, pins}, {1'b0, model}, msg);
	endtask

	task automatic host_write(input logic [6:0] addr, input logic [7:0] data);
		@(posedge CLK);
		a    <= addr[6:1];
		di   <= data;
		cs_n <= 1'b0;
		rw_n <= 1'b0;
		repeat (3) @(posedge CLK);
		cs_n <= 1'b1;
		rw_n <= 1'b1;
	endtask

	task automatic host_read(input logic [6:0] addr, output logic [7:0] data);
		@(posedge CLK);
		a    <= addr[6:1];
		cs_n <= 1'b0;	// rw_n stays high
		repeat (3) @(posedge CLK);
		cs_n <= 1'b1;
		@(negedge CLK);
		data = dout;
	endtask

	task automatic wait_sf_clear();
		logic [7:0] sf;
		sf = 8'h01;
		while (sf != 8'h00)
			host_read(ADDR_SF, sf);
	endtask

	function automatic logic [7:0] status_of(input smpc_pkg::reset_lines_t l, input logic r);
		logic [7:0] s;
		s    = 8'h34;	// Bits 2, 4 and 5 always set
		s[0] = !l.sndres_n;
		s[1] = !l.sysres_n;
		s[3] = !l.mshnmi_n;
		s[6] = !l.cdres_n;
		s[7] = r;
		return s;
	endfunction

	task automatic model_apply(input logic [7:0] code);
		case (code)
			smpc_pkg::MSHON: begin
				model.mshres_n = 1'b1;
				model.mshnmi_n = 1'b1;
			end
			smpc_pkg::SSHON: begin
				model.sshres_n = 1'b1;
				model.sshnmi_n = 1'b1;
			end
			smpc_pkg::SSHOFF: begin
				model.sshres_n = 1'b0;
				model.sshnmi_n = 1'b1;
			end
			smpc_pkg::SNDON:   model.sndres_n = 1'b1;
			smpc_pkg::SNDOFF:  model.sndres_n = 1'b0;
			smpc_pkg::CDON:    model.cdres_n = 1'b1;
			smpc_pkg::CDOFF:   model.cdres_n = 1'b0;
			smpc_pkg::SYSRES:  model = '0;
			smpc_pkg::NMIREQ:  model.mshnmi_n = 1'b0;
			smpc_pkg::RESENAB: model_resd = 1'b0;
			smpc_pkg::RESDISA: model_resd = 1'b1;
			default: ;
		endcase
	endtask

	task automatic model_release(input logic [7:0] code);
		if (code == smpc_pkg::SYSRES)
			model = '1;
		else if (code == smpc_pkg::NMIREQ)
			model.mshnmi_n = 1'b1;
	endtask

	task automatic run_cmd(input logic [7:0] code);
		logic [7:0] exp_status;
		host_write(ADDR_SF, 8'h01);
		host_write(ADDR_COMREG, code);
		wait_sf_clear();
		model_apply(code);
		exp_status = status_of(model, model_resd);	// Captured between apply and release
		model_release(code);
		host_read(ADDR_OREG31, rdata);
		check(rdata, code, "OREG31 holds the command code");
		host_read(ADDR_OREG10, rdata);
		check(rdata, exp_status, "OREG10 status byte");
		check_lines("line levels after command");
		host_read(ADDR_SF, rdata);
		check(rdata, 8'h00, "SF after command");
	endtask

	initial begin
		cycles     = 0;
		RST_N      = 1'b0;
		CE         = 1'b1;
		MRES_N     = 1'b1;
		a          = '0;
		di         = '0;
		cs_n       = 1'b1;
		rw_n       = 1'b1;
		model      = '0;
		model_resd = 1'b1;
		repeat (4) @(posedge CLK);
		RST_N <= 1'b1;
		check_lines("all lines asserted after reset");

		@(posedge CLK);
		MRES_N <= 1'b0;
		repeat (2) @(posedge CLK);
		MRES_N <= 1'b1;
		model = 7'b1101101;	// Slave CPU and sound held
		check_lines("power-on pattern after master reset");
		host_read(ADDR_SF, rdata);
		check(rdata, 8'h00, "SF after reset");
		host_read(7'h61, rdata);
		check(rdata, 8'h00, "unmapped 0x61 after reset");

		run_cmd(smpc_pkg::MSHON);
		run_cmd(smpc_pkg::SSHON);
		run_cmd(smpc_pkg::SSHOFF);
		run_cmd(smpc_pkg::SNDON);
		run_cmd(smpc_pkg::SNDOFF);
		run_cmd(smpc_pkg::CDON);
		run_cmd(smpc_pkg::CDOFF);
		run_cmd(smpc_pkg::SYSRES);
		run_cmd(smpc_pkg::NMIREQ);
		run_cmd(smpc_pkg::RESENAB);
		run_cmd(smpc_pkg::RESDISA);
		run_cmd(8'h05);

		// CDOFF is replaced while RESDISA waits
		host_write(ADDR_SF, 8'h01);
		host_write(ADDR_COMREG, smpc_pkg::RESDISA);
		host_write(ADDR_COMREG, smpc_pkg::CDOFF);
		host_write(ADDR_COMREG, 8'h05);
		wait_sf_clear();
		rdata = smpc_pkg::RESDISA;
		while (rdata == smpc_pkg::RESDISA)
			host_read(ADDR_OREG31, rdata);
		check(rdata, 8'h05, "only the last pending code runs");
		check_lines("lines after replaced code");

		host_read(7'h01, rdata);
		check(rdata, 8'h00, "unmapped 0x01 read");
		host_read(7'h7F, rdata);
		check(rdata, 8'h00, "unmapped 0x7F read");
		host_read(ADDR_COMREG, rdata);
		check(rdata, 8'h00, "COMREG is not readable");
		host_write(7'h0D, 8'hFF);
		host_write(7'h61, 8'h01);
		host_read(ADDR_SF, rdata);
		check(rdata, 8'h00, "SF after unmapped writes");
		host_read(7'h0D, rdata);
		check(rdata, 8'h00, "0x0D after unmapped write");
		host_read(ADDR_OREG31, rdata);
		check(rdata, 8'h05, "OREG31 after unmapped writes");
		host_read(ADDR_OREG10, rdata);
		check(rdata, status_of(model, model_resd), "OREG10 after unmapped writes");
		check_lines("lines after unmapped writes");

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- vlog.f
source/smpc_pkg.sv
source/smpc_host_bus.sv
source/smpc_cmd_fsm.sv
source/smpc_wait_timer.sv
source/smpc_reset_ctrl.sv
source/smpc_oreg_ram.sv
source/smpc_top.sv
tb/smpc_tb.sv
